// File: verification/cart_addr_testdata.txt
# kind 0 cfg write: sel data 0 0 0 | kind 1 access: addr pa romsel_n rom_addr flags(rom,sram,wr,vect)
# kind 2 hold: addr pa edges enables(msu,cx4,r213f) 0 | all fields hex
2 000000 00 2 0 0
1 C12345 00 0 012345 8
1 FFFFE4 00 0 3FFFE4 9
0 0 000001 0 0 0
0 1 0FFFFF 0 0 0
0 2 001FFF 0 0 0
1 808000 00 0 000000 8
1 9FABCD 00 0 0FABCD 8
1 701234 00 1 E01234 6
1 7D7FFF 00 1 E01FFF 6
1 7E1234 00 1 0F1234 0
0 0 000000 0 0 0
1 206000 00 1 E00000 6
1 BF7ABC 00 1 E01ABC 6
1 406000 00 0 006000 8
0 0 000002 0 0 0
1 701234 00 1 081234 0
1 00FFE0 00 0 007FE0 9
1 00FFDF 00 0 007FDF 8
2 006000 00 5 0 0
2 006000 00 1 2 0
2 000000 00 2 2 0
2 000000 00 1 0 0
2 002000 00 6 0 0
0 3 000001 0 0 0
2 002007 00 5 0 0
2 002007 00 1 4 0
2 002008 00 3 0 0
2 002003 00 3 0 0
2 808000 00 4 0 0
2 402000 00 6 0 0
2 808000 3F 5 0 0
2 808000 3F 1 1 0
2 808000 00 3 0 0
2 808000 3F 3 0 0
2 808000 00 4 0 0

// File: sim.f
logic/cart_pkg.sv
logic/map_config_regs.sv
logic/address_decode.sv
logic/hit_filter.sv
logic/cart_addr_top.sv
verification/cart_addr_tb.sv

// File: Bender.yml
package:
  name: cart_addr

sources:
  - files:
      - logic/cart_pkg.sv
      - logic/map_config_regs.sv
      - logic/address_decode.sv
      - logic/hit_filter.sv
      - logic/cart_addr_top.sv
  - target: simulation
    files:
      - verification/cart_addr_tb.sv

// File: verification/cart_addr_tb.sv
module cart_addr_tb
  import cart_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int PERIOD         = 100;
  localparam int SWEEP_PER_MODE = 40;
  localparam int SWEEP_CYCLES   = 3 * (SWEEP_PER_MODE + 1);  // Mapper write plus accesses
  localparam string DATA_FILE   = "verification/cart_addr_testdata.txt";

  // One line of the data file
  typedef struct packed {
    logic [3:0]  kind;  // 0 cfg write, 1 access, 2 hold
    logic [23:0] f1;
    logic [23:0] f2;
    logic [23:0] f3;
    logic [23:0] f4;
    logic [23:0] f5;
  } rec_t;

  logic       CLK;
  logic       rst_n;
  logic       cfg_we;
  cfg_sel_t   cfg_sel;
  cfg_data_t  cfg_data;
  snes_addr_t snes_addr;
  snes_pa_t   snes_pa;
  logic       snes_romsel_n;
  cart_addr_t rom_addr;
  logic       is_rom;
  logic       is_saveram;
  logic       is_writable;
  logic       cx4_vect_enable;
  logic       msu_enable;
  logic       cx4_enable;
  logic       r213f_enable;

  rec_t       recs[$];
  int         rec_cycles = 0;  // Clock cycles the records take
  bit         loaded     = 1'b0;
  logic [2:0] sh_mode;         // Shadow of the mapping config
  addr_mask_t sh_rom_mask;
  addr_mask_t sh_sram_mask;

  cart_addr_top #(.FILTER_DEPTH(6), .FILTER_SKIP(2)) u_cart_addr_top (.*);

  initial begin : clock_gen
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic stop_with_error(string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_addr(string name, cart_addr_t got, cart_addr_t exp);
    if (got !== exp)
      stop_with_error($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp)
      stop_with_error($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Mapping rules, written from the memory map
  function automatic void model_access(input snes_addr_t a, input logic romsel_n,
                                       output cart_addr_t addr, output logic [3:0] flags);
    logic [7:0]  bank;
    logic [15:0] off;
    cart_addr_t  folded;
    logic        sram;
    bank = a[23:16];
    off  = a[15:0];
    if (sh_mode == MAP_HIROM) begin
      folded = {2'b00, a[21:0]};  // 64K banks
      sram   = ((bank >= 8'h20 && bank <= 8'h3F) || (bank >= 8'hA0 && bank <= 8'hBF))
               && off >= 16'h6000 && off <= 16'h7FFF;
    end else begin
      folded = {2'b00, a[22:16], a[14:0]};  // 32K banks
      sram   = (sh_mode != MAP_CX4) && bank >= 8'h70 && bank <= 8'h7D && off < 16'h8000;
    end
    addr  = sram ? (SAVERAM_BASE | (folded & sh_sram_mask)) : (folded & sh_rom_mask);
    flags = {~romsel_n, sram, sram, off >= 16'hFFE0};  // rom, sram, writable, vector
  endfunction

  task automatic load_records();
    int          fd;
    string       line;
    rec_t        r;
    logic [23:0] k, a, b, c, d, e;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0)
      stop_with_error({"Could not open the test data file ", DATA_FILE});
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;  // Blank or column notes
      if ($sscanf(line, "%h %h %h %h %h %h", k, a, b, c, d, e) != 6)
        stop_with_error({"Malformed test data line: ", line});
      r = '{kind: k[3:0], f1: a, f2: b, f3: c, f4: d, f5: e};
      recs.push_back(r);
      rec_cycles += (r.kind == 4'd2) ? int'(r.f3) : 1;
    end
    $fclose(fd);
    if (recs.size() == 0)
      stop_with_error("The test data file holds no records");
  endtask

  task automatic wait_sample();
    @(posedge CLK);
    #(PERIOD / 4);  // Between rising and falling edge
  endtask

  task automatic drive_bus(snes_addr_t addr, snes_pa_t pa, logic romsel_n);
    cfg_we        = 1'b0;
    snes_addr     = addr;
    snes_pa       = pa;
    snes_romsel_n = romsel_n;
  endtask

  task automatic write_cfg(cfg_sel_t sel, cfg_data_t data);
    cfg_we   = 1'b1;
    cfg_sel  = sel;
    cfg_data = data;
    case (sel)
      CFG_MAPPER:       sh_mode = (data[2:0] == MAP_HIROM || data[2:0] == MAP_CX4) ?
                                  data[2:0] : MAP_LOROM;
      CFG_ROM_MASK:     sh_rom_mask  = data;
      CFG_SAVERAM_MASK: sh_sram_mask = data;
      default:          ;  // MSU-1 flag only shows in the enables
    endcase
    wait_sample();
  endtask

  task automatic check_access(cart_addr_t exp_addr, logic [3:0] exp_flags);
    check_addr("rom_addr", rom_addr, exp_addr);
    check_flag("is_rom", is_rom, exp_flags[3]);
    check_flag("is_saveram", is_saveram, exp_flags[2]);
    check_flag("is_writable", is_writable, exp_flags[1]);
    check_flag("cx4_vect_enable", cx4_vect_enable, exp_flags[0]);
  endtask

  task automatic check_enables(logic [2:0] exp);  // msu, cx4, r213f
    check_flag("msu_enable", msu_enable, exp[2]);
    check_flag("cx4_enable", cx4_enable, exp[1]);
    check_flag("r213f_enable", r213f_enable, exp[0]);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main
    rec_t        r;
    cart_addr_t  m_addr;
    logic [3:0]  m_flags;
    logic [31:0] rnd;
    snes_addr_t  addr;
    rst_n        = 1'b0;
    cfg_sel      = '0;
    cfg_data     = '0;
    drive_bus('0, '0, 1'b1);
    sh_mode      = MAP_HIROM;  // Reset values of the config
    sh_rom_mask  = 24'hFFFFFF;
    sh_sram_mask = '0;
    load_records();
    loaded = 1'b1;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;

    foreach (recs[i]) begin
      r = recs[i];
      @(negedge CLK);
      case (r.kind)
        4'd0: write_cfg(r.f1[1:0], r.f2);
        4'd1: begin
          drive_bus(r.f1, r.f2[7:0], r.f3[0]);
          wait_sample();
          model_access(r.f1, r.f3[0], m_addr, m_flags);
          if (m_addr !== r.f4 || m_flags !== r.f5[3:0])
            stop_with_error($sformatf("Model and test data disagree at record %0d", i));
          check_access(r.f4, r.f5[3:0]);
        end
        4'd2: begin
          drive_bus(r.f1, r.f2[7:0], 1'b1);  // Held for f3 sampling edges
          repeat (r.f3) @(posedge CLK);
          #(PERIOD / 4);
          check_enables(r.f4[2:0]);
        end
        default: stop_with_error($sformatf("Unknown record kind at record %0d", i));
      endcase
    end

    // Random sweep, one block per mapping mode
    rnd = 32'd10;
    for (int m = 0; m < 3; m++) begin
      @(negedge CLK);
      write_cfg(CFG_MAPPER, cfg_data_t'(m));
      for (int k = 0; k < SWEEP_PER_MODE; k++) begin
        rnd  = xorshift32(rnd);
        addr = rnd[23:0];
        if (k % 3 == 0) begin  // Steer toward the save RAM windows
          addr[23:21] = (m == 0) ? 3'b001 : 3'b011;
          addr[15:13] = 3'b011;
        end
        @(negedge CLK);
        drive_bus(addr, rnd[31:24], rnd[13]);
        wait_sample();
        model_access(addr, rnd[13], m_addr, m_flags);
        check_access(m_addr, m_flags);
      end
    end

    @(negedge CLK);
    drive_bus('0, '0, 1'b1);
    $display("TEST PASS");
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    #((rec_cycles + SWEEP_CYCLES + 100) * PERIOD);
    $display("Timeout: the test did not finish within the expected number of cycles");
    $display("TEST FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: logic/cart_addr_top.sv
module cart_addr_top
  import cart_pkg::*;
#(
  parameter int unsigned FILTER_DEPTH = 6,
  parameter int unsigned FILTER_SKIP  = 2
) (
  input  logic       CLK,
  input  logic       rst_n,
  // MCU config port
  input  logic       cfg_we,
  input  cfg_sel_t   cfg_sel,
  input  cfg_data_t  cfg_data,
  // Console bus
  input  snes_addr_t snes_addr,
  input  snes_pa_t   snes_pa,
  input  logic       snes_romsel_n,
  // Memory side
  output cart_addr_t rom_addr,
  output logic       is_rom,
  output logic       is_saveram,
  output logic       is_writable,
  output logic       cx4_vect_enable,
  // Qualified enables
  output logic       msu_enable,
  output logic       cx4_enable,
  output logic       r213f_enable
);

  timeunit 1ns;
  timeprecision 1ns;

  map_cfg_if u_cfg_if ();

  logic msu_hit;    // Unfiltered region hits
  logic cx4_hit;
  logic r213f_hit;

  //////////////////////////////
  // Config and decode
  //////////////////////////////

  map_config_regs u_regs (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .cfg_we   (cfg_we),
    .cfg_sel  (cfg_sel),
    .cfg_data (cfg_data),
    .cfg      (u_cfg_if.cfg)
  );

  address_decode u_decode (
    .snes_addr       (snes_addr),
    .snes_pa         (snes_pa),
    .snes_romsel_n   (snes_romsel_n),
    .cfg             (u_cfg_if.dec),
    .rom_addr        (rom_addr),
    .is_rom          (is_rom),
    .is_saveram      (is_saveram),
    .is_writable     (is_writable),
    .cx4_vect_enable (cx4_vect_enable),
    .msu_hit         (msu_hit),
    .cx4_hit         (cx4_hit),
    .r213f_hit       (r213f_hit)
  );

  //////////////////////////////
  // Hit qualifiers
  //////////////////////////////

  hit_filter #(.DEPTH(FILTER_DEPTH), .SKIP(FILTER_SKIP)) u_msu_filter (
    .CLK (CLK), .rst_n (rst_n), .hit (msu_hit), .enable (msu_enable)
  );

  hit_filter #(.DEPTH(FILTER_DEPTH), .SKIP(FILTER_SKIP)) u_cx4_filter (
    .CLK (CLK), .rst_n (rst_n), .hit (cx4_hit), .enable (cx4_enable)
  );

  hit_filter #(.DEPTH(FILTER_DEPTH), .SKIP(FILTER_SKIP)) u_r213f_filter (
    .CLK (CLK), .rst_n (rst_n), .hit (r213f_hit), .enable (r213f_enable)
  );

endmodule

// File: logic/hit_filter.sv
module hit_filter #(
  parameter int unsigned DEPTH = 6,  // Total sample stages
  parameter int unsigned SKIP  = 2   // Youngest stages ignored
) (
  input  logic CLK,
  input  logic rst_n,
  input  logic hit,     // Raw decode, may glitch
  output logic enable   // Qualified, level
);

  //////////////////////////////
  // Sample history
  //////////////////////////////

  logic [DEPTH-1:0] stages;  // Bit 0 newest

  if (SKIP >= DEPTH) begin : g_bad_params
    $error("hit_filter needs DEPTH greater than SKIP");
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      stages <= '0;
    end else begin
      stages <= (stages << 1) | DEPTH'(hit);
    end
  end

  // Address must have settled through the skip stages and then held
  assign enable = &stages[DEPTH-1:SKIP];

  // Oldest and newest qualifying samples were both hits
  assert property (@(posedge CLK) disable iff (!rst_n)
    enable |-> ($past(hit, SKIP + 1) && $past(hit, DEPTH)))
    else $error("Filter enable without a held hit");

endmodule

// File: logic/address_decode.sv
module address_decode
  import cart_pkg::*;
(
  input  snes_addr_t snes_addr,      // Console A-bus
  input  snes_pa_t   snes_pa,        // Console B-bus
  input  logic       snes_romsel_n,  // ROM chip select, active low
  map_cfg_if.dec     cfg,
  output cart_addr_t rom_addr,       // Physical memory address
  output logic       is_rom,
  output logic       is_saveram,
  output logic       is_writable,
  output logic       cx4_vect_enable,
  output logic       msu_hit,        // Raw hits, filtered downstream
  output logic       cx4_hit,
  output logic       r213f_hit
);

  logic [7:0]  bank;
  logic [15:0] offset;
  logic        mode_hirom;
  logic        mode_cx4;
  cart_addr_t  lorom_addr;
  cart_addr_t  hirom_addr;
  cart_addr_t  folded_addr;
  logic        lorom_sram;
  logic        hirom_sram;

  assign bank   = snes_addr[23:16];
  assign offset = snes_addr[15:0];

  assign mode_hirom = (cfg.mapper == MAP_HIROM);
  assign mode_cx4   = (cfg.mapper == MAP_CX4);  // Anything else is LoROM

  //////////////////////////////
  // Address folding
  //////////////////////////////

  // LoROM drops A15 and A23, 32K per bank
  assign lorom_addr  = {2'b00, snes_addr[22:16], snes_addr[14:0]};
  assign hirom_addr  = {2'b00, snes_addr[21:0]};  // 64K banks, mirrored
  assign folded_addr = mode_hirom ? hirom_addr : lorom_addr;

  //////////////////////////////
  // Save RAM regions
  //////////////////////////////

  // Banks 70-7D, lower half
  assign lorom_sram = (bank >= 8'h70) && (bank <= 8'h7D) && !offset[15];
  // Banks 20-3F and A0-BF, 6000-7FFF
  assign hirom_sram = (bank[6:5] == 2'b01) && (offset[15:13] == WIN_6000_TAG);

  always_comb begin
    case (cfg.mapper)
      MAP_HIROM: is_saveram = hirom_sram;
      MAP_CX4:   is_saveram = 1'b0;  // Window taken by Cx4 MMIO
      default:   is_saveram = lorom_sram;
    endcase
  end

  assign is_writable = is_saveram;
  assign is_rom      = ~snes_romsel_n;

  assign rom_addr = is_saveram ? (SAVERAM_BASE | (folded_addr & cfg.saveram_mask))
                               : (folded_addr & cfg.rom_mask);

  // Cx4 vector table FFE0-FFFF
  assign cx4_vect_enable = &offset[15:5];

  //////////////////////////////
  // Raw special-region hits
  //////////////////////////////

  assign msu_hit   = cfg.use_msu1 && !snes_addr[22] && ((offset & MSU_MASK) == MSU_BASE);
  assign cx4_hit   = mode_cx4 && !snes_addr[22] && (offset[15:13] == WIN_6000_TAG);
  assign r213f_hit = (snes_pa == R213F_PA);

  always_comb begin
    assert final (!(mode_cx4 && is_saveram))
      else $error("Save RAM decoded while in Cx4 mode");
  end

  // Config is known once out of reset, so hits must be too
  always_comb begin
    if (!$isunknown({cfg.mapper, cfg.use_msu1})) begin
      assert final (!$isunknown({msu_hit, cx4_hit, r213f_hit}))
        else $error("Unknown raw hit after reset");
    end
  end

endmodule

// File: logic/map_config_regs.sv
// Mapping configuration as seen by the decoder
interface map_cfg_if
  import cart_pkg::*;
();

  map_mode_e  mapper;        // Current mapping mode
  addr_mask_t rom_mask;      // ROM size mask
  addr_mask_t saveram_mask;  // Save RAM size mask
  logic       use_msu1;      // MSU-1 present

  modport cfg (output mapper, rom_mask, saveram_mask, use_msu1);
  modport dec (input mapper, rom_mask, saveram_mask, use_msu1);

endinterface


module map_config_regs
  import cart_pkg::*;
(
  input  logic      CLK,
  input  logic      rst_n,
  input  logic      cfg_we,    // One register per cycle
  input  cfg_sel_t  cfg_sel,
  input  cfg_data_t cfg_data,
  map_cfg_if.cfg    cfg
);

  //////////////////////////////
  // Write decode
  //////////////////////////////

  logic       wr_mapper;
  logic       wr_rom_mask;
  logic       wr_saveram_mask;
  logic       wr_flags;
  map_mode_e  mapper_wr;      // Normalized mapper code

  map_mode_e  mapper_q;
  addr_mask_t rom_mask_q;
  addr_mask_t saveram_mask_q;
  logic       use_msu1_q;

  assign wr_mapper       = cfg_we && (cfg_sel == CFG_MAPPER);
  assign wr_rom_mask     = cfg_we && (cfg_sel == CFG_ROM_MASK);
  assign wr_saveram_mask = cfg_we && (cfg_sel == CFG_SAVERAM_MASK);
  assign wr_flags        = cfg_we && (cfg_sel == CFG_FLAGS);

  // Unknown codes stored as LoROM
  always_comb begin
    case (cfg_data[2:0])
      MAP_HIROM: mapper_wr = MAP_HIROM;
      MAP_CX4:   mapper_wr = MAP_CX4;
      default:   mapper_wr = MAP_LOROM;
    endcase
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mapper_q       <= MAP_HIROM;
      rom_mask_q     <= 24'hFFFFFF;  // Whole ROM until MCU sizes it
      saveram_mask_q <= '0;          // No save RAM
      use_msu1_q     <= 1'b0;
    end else begin
      if (wr_mapper)       mapper_q       <= mapper_wr;
      if (wr_rom_mask)     rom_mask_q     <= cfg_data;
      if (wr_saveram_mask) saveram_mask_q <= cfg_data;
      if (wr_flags)        use_msu1_q     <= cfg_data[FLAG_MSU1_BIT];
    end
  end

  assign cfg.mapper       = mapper_q;
  assign cfg.rom_mask     = rom_mask_q;
  assign cfg.saveram_mask = saveram_mask_q;
  assign cfg.use_msu1     = use_msu1_q;

  // Mode seen by the decoder is always a legal one after a mapper write
  assert property (@(posedge CLK) disable iff (!rst_n)
    wr_mapper |=> (cfg.mapper inside {MAP_HIROM, MAP_LOROM, MAP_CX4}))
    else $error("Mapper register holds an illegal mode code");

endmodule

// File: logic/cart_pkg.sv
package cart_pkg;

  //////////////////////////////
  // Bus and memory types
  //////////////////////////////

  typedef logic [23:0] snes_addr_t;  // Console A-bus address
  typedef logic [23:0] cart_addr_t;  // Physical address into cart memory
  typedef logic [23:0] addr_mask_t;  // Size mask on the physical address
  typedef logic [7:0]  snes_pa_t;    // B-bus peripheral address

  // Microcontroller configuration port
  typedef logic [23:0] cfg_data_t;
  typedef logic [1:0]  cfg_sel_t;

  // Mapping modes, codes as written by the MCU
  // Unlisted codes fall back to LoROM
  typedef enum logic [2:0] {
    MAP_HIROM = 3'd0,
    MAP_LOROM = 3'd1,
    MAP_CX4   = 3'd2   // LoROM plus MMIO at 6000-7FFF
  } map_mode_e;

  //////////////////////////////
  // Configuration register map
  //////////////////////////////

  localparam cfg_sel_t CFG_MAPPER       = 2'd0;  // Low 3 bits taken
  localparam cfg_sel_t CFG_ROM_MASK     = 2'd1;
  localparam cfg_sel_t CFG_SAVERAM_MASK = 2'd2;
  localparam cfg_sel_t CFG_FLAGS        = 2'd3;  // Bit 0 = MSU-1 enable

  localparam int unsigned FLAG_MSU1_BIT = 0;

  //////////////////////////////
  // Fixed addresses
  //////////////////////////////

  localparam cart_addr_t SAVERAM_BASE = 24'hE00000;  // Save RAM above ROM
  localparam snes_pa_t   R213F_PA     = 8'h3F;       // PPU status, $213F

  localparam logic [15:0] MSU_BASE = 16'h2000;  // MSU-1 regs 2000-2007
  localparam logic [15:0] MSU_MASK = 16'hFFF8;

  // Offset bits 15-13 of the 6000-7FFF window
  localparam logic [2:0] WIN_6000_TAG = 3'b011;

endpackage
